// File: hdl/alu_pkg.sv
package alu_pkg;

    // Default operand and result width
    localparam int DATA_WIDTH = 8;

    // Width of the operation select
    localparam int OP_WIDTH = 3;

    // One operand or result word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Operation codes
    typedef enum logic [OP_WIDTH-1:0] {
        op_mov = 3'd0,
        op_add = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_mul = 3'd4,
        op_shl = 3'd5,
        op_sha = 3'd6,
        op_rot = 3'd7
    } alu_op_t;

    // Fill rule for the barrel shifter
    typedef enum logic [1:0] {
        shift_logical = 2'd0,
        shift_arith   = 2'd1,
        shift_rotate  = 2'd2
    } shift_kind_t;

endpackage

// File: hdl/alu_multiplier.sv
module alu_multiplier #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] product
);

    // Row i holds the running sum from product bit i upward.
    // Only WIDTH - i bits of it can reach the low half of the product,
    // so each row is one bit shorter than the one before.
    for (genvar i = 0; i < WIDTH; i++) begin : g_row
        localparam int LEN = WIDTH - i;

        logic [LEN-1:0] pp;
        logic [LEN-1:0] sum;

        // Partial products of b[i], already aligned to bit i
        assign pp = a[LEN-1:0] & {LEN{b[i]}};

        if (i == 0) begin : g_first
            assign sum = pp;
        end else begin : g_add
            logic [LEN-1:0] prev;
            logic [LEN-1:0] carry;

            // Bit 0 of the row above already left as a product bit
            assign prev     = g_row[i-1].sum[LEN:1];
            assign carry[0] = 1'b0;

            // Ripple chain of full adders
            for (genvar j = 0; j < LEN; j++) begin : g_fa
                assign sum[j] = prev[j] ^ pp[j] ^ carry[j];

                // Carry out of the top bit would land past the low half
                if (j < LEN - 1) begin : g_carry
                    assign carry[j+1] = (prev[j] & pp[j]) | (carry[j] & (prev[j] ^ pp[j]));
                end
            end
        end

        // Lowest bit of each row is final
        assign product[i] = sum[0];
    end

endmodule

// File: hdl/alu_shifter.sv
module alu_shifter
    import alu_pkg::*;
#(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] data,
    input  logic [WIDTH-1:0] amount,
    input  shift_kind_t      kind,
    output logic [WIDTH-1:0] shifted
);

    localparam int STAGES = $clog2(WIDTH);

    logic              go_right;
    logic [WIDTH-1:0]  magnitude;
    logic [STAGES-1:0] step;
    logic              out_of_range;
    logic              is_arith;
    logic              is_rotate;
    logic [WIDTH-1:0]  stage [0:STAGES];

    assign is_arith  = (kind == shift_arith);
    assign is_rotate = (kind == shift_rotate);

    // Sign of amount picks the direction, magnitude the distance
    assign go_right  = amount[WIDTH-1];
    assign magnitude = go_right ? -amount : amount;

    assign out_of_range = (magnitude >= WIDTH);

    // Rotate wraps the distance, the other kinds are overridden when too far
    always_comb begin
        if (is_rotate) begin
            step = STAGES'(magnitude % WIDTH);
        end else begin
            step = magnitude[STAGES-1:0];
        end
    end

    assign stage[0] = data;

    // Stage k moves the word by 2**k when step[k] is set
    for (genvar k = 0; k < STAGES; k++) begin : g_stage
        localparam int S = 1 << k;

        logic [WIDTH-1:0] cur;
        logic [WIDTH-1:0] next;

        assign cur = stage[k];

        for (genvar j = 0; j < WIDTH; j++) begin : g_bit
            logic to_left;
            logic to_right;

            // Left move, bit j takes bit j - S
            if (j >= S) begin : g_left_in
                // Arithmetic left keeps the sign bit where it is
                assign to_left = (is_arith && (j == WIDTH - 1)) ? cur[j] : cur[j-S];
            end else begin : g_left_fill
                assign to_left = is_rotate ? cur[j-S+WIDTH] : 1'b0;
            end

            // Right move, bit j takes bit j + S
            if (j + S < WIDTH) begin : g_right_in
                assign to_right = cur[j+S];
            end else begin : g_right_fill
                always_comb begin
                    if (is_rotate) begin
                        to_right = cur[j+S-WIDTH];
                    end else if (is_arith) begin
                        to_right = cur[WIDTH-1];
                    end else begin
                        to_right = 1'b0;
                    end
                end
            end

            // Two-way mux per bit, then the bypass when this stage is idle
            assign next[j] = step[k] ? (go_right ? to_right : to_left) : cur[j];
        end

        assign stage[k+1] = next;
    end

    // Distances of WIDTH or more
    always_comb begin
        shifted = stage[STAGES];
        if (out_of_range && !is_rotate) begin
            if (is_arith) begin
                if (go_right) begin
                    shifted = {WIDTH{data[WIDTH-1]}};
                end else begin
                    shifted = {data[WIDTH-1], {(WIDTH - 1){1'b0}}};
                end
            end else begin
                shifted = '0;
            end
        end
    end

endmodule

// File: hdl/alu.sv
module alu
    import alu_pkg::*;
#(
    parameter int WIDTH = DATA_WIDTH
) (
    input  logic    clk,
    input  logic    reset,
    input  alu_op_t op,
    input  data_t   a,
    input  data_t   b,
    output data_t   result,
    output logic    zero
);

    logic [WIDTH-1:0] mov_result;
    logic [WIDTH-1:0] add_result;
    logic [WIDTH-1:0] and_result;
    logic [WIDTH-1:0] or_result;
    logic [WIDTH-1:0] mul_result;
    logic [WIDTH-1:0] shift_result;
    logic [WIDTH-1:0] next_result;
    shift_kind_t      shift_kind;

    // Single-operator functions
    assign mov_result = b;
    // Plain wrapping sum, subtraction comes from a negated b
    assign add_result = a + b;
    assign and_result = a & b;
    assign or_result  = a | b;

    alu_multiplier #(
        .WIDTH(WIDTH)
    ) u_multiplier (
        .a      (a),
        .b      (b),
        .product(mul_result)
    );

    // Operation code to shifter fill rule
    always_comb begin
        case (op)
            op_sha:  shift_kind = shift_arith;
            op_rot:  shift_kind = shift_rotate;
            default: shift_kind = shift_logical;
        endcase
    end

    // b is the signed shift amount, a is the word being shifted
    alu_shifter #(
        .WIDTH(WIDTH)
    ) u_shifter (
        .data   (a),
        .amount (b),
        .kind   (shift_kind),
        .shifted(shift_result)
    );

    // Result select
    always_comb begin
        next_result = mov_result;
        case (op)
            op_mov: next_result = mov_result;
            op_add: next_result = add_result;
            op_and: next_result = and_result;
            op_or:  next_result = or_result;
            op_mul: next_result = mul_result;
            op_shl: next_result = shift_result;
            op_sha: next_result = shift_result;
            op_rot: next_result = shift_result;
            default: next_result = mov_result;
        endcase
    end

    // Output stage, one cycle after sampling
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            zero   <= 1'b0;
        end else begin
            result <= next_result;
            // Flag tracks the sum for every operation, as a branch compare
            zero   <= (add_result == '0);
        end
    end

endmodule

// File: verif/alu_tb.sv
module alu_tb
    import alu_pkg::*;
();

    localparam int RESET_CYCLES  = 8;
    localparam int BASIC_VECTORS = 43;
    localparam int MUL_VECTORS   = 29;
    localparam int SHIFT_VECTORS = 40;
    localparam int TEST_COUNT    = 6;
    localparam int TOTAL_VECTORS = BASIC_VECTORS + MUL_VECTORS + 3 * SHIFT_VECTORS;
    // One drain cycle per test on top of the vectors
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + TOTAL_VECTORS + TEST_COUNT);

    logic    clk;
    logic    reset;
    alu_op_t op_in;
    data_t   a_in;
    data_t   b_in;
    data_t   result;
    logic    zero;

    // Operation waiting for its registered result
    logic    pend_valid;
    alu_op_t pend_op;
    data_t   pend_a;
    data_t   pend_b;
    data_t   pend_result;
    logic    pend_zero;

    logic [15:0] lfsr_state;
    int          pass_count;
    int          fail_count;
    int          cycle_count;

    alu #(
        .WIDTH(DATA_WIDTH)
    ) u_dut (
        .clk   (clk),
        .reset (reset),
        .op    (op_in),
        .a     (a_in),
        .b     (b_in),
        .result(result),
        .zero  (zero)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles",
                     TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    task automatic random_byte(output data_t v);
        int i;
        for (i = 0; i < DATA_WIDTH; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    // Expected result from the operation rules
    function automatic data_t expected_result(input alu_op_t op_v, input data_t a_v,
                                              input data_t b_v);
        int          amt;
        int          mag;
        int          m;
        logic [15:0] wide;
        data_t       r;
        amt = $signed(b_v);
        mag = (amt < 0) ? -amt : amt;
        m = mag % 8;
        r = '0;
        case (op_v)
            op_mov: r = b_v;
            op_add: r = a_v + b_v;
            op_and: r = a_v & b_v;
            op_or:  r = a_v | b_v;
            op_mul: begin
                wide = a_v * b_v;
                r = wide[7:0];
            end
            op_shl: begin
                if (mag >= 8) begin
                    r = '0;
                end else if (amt >= 0) begin
                    wide = {8'h00, a_v} << mag;
                    r = wide[7:0];
                end else begin
                    r = a_v >> mag;
                end
            end
            op_sha: begin
                if (amt >= 0) begin
                    wide = (mag >= 8) ? 16'h0000 : ({8'h00, a_v} << mag);
                    r = {a_v[7], wide[6:0]};
                end else if (mag >= 8) begin
                    r = {8{a_v[7]}};
                end else begin
                    r = $signed(a_v) >>> mag;
                end
            end
            op_rot: begin
                // Doubled word, any 8-bit window is a rotation
                if (amt >= 0) begin
                    wide = {a_v, a_v} >> (8 - m);
                end else begin
                    wide = {a_v, a_v} >> m;
                end
                r = wide[7:0];
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic expected_zero(input data_t a_v, input data_t b_v);
        data_t s;
        s = a_v + b_v;
        return (s == 8'h00);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_count++;
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_pending();
        string tag;
        if (pend_valid) begin
            tag = $sformatf("op %0d a 0x%02h b 0x%02h", pend_op, pend_a, pend_b);
            check_value(result, pend_result, {tag, " result"});
            check_value(zero, pend_zero, {tag, " zero flag"});
        end
    endtask

    // New vector every cycle, previous one checked at the same point
    task automatic apply(input alu_op_t op_v, input data_t a_v, input data_t b_v);
        @(posedge clk);
        #1;
        check_pending();
        op_in = op_v;
        a_in = a_v;
        b_in = b_v;
        pend_valid = 1'b1;
        pend_op = op_v;
        pend_a = a_v;
        pend_b = b_v;
        pend_result = expected_result(op_v, a_v, b_v);
        pend_zero = expected_zero(a_v, b_v);
    endtask

    task automatic drain();
        @(posedge clk);
        #1;
        check_pending();
        pend_valid = 1'b0;
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("%s: done, all checks matched", name);
        end else begin
            $display("%s: done, %0d mismatches", name, fail_count - fails_before);
        end
    endtask

    task automatic test_reset();
        int fails_before;
        fails_before = fail_count;
        // Operands that would raise the flag if sampled
        op_in = op_add;
        a_in = 8'h05;
        b_in = 8'hfb;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_value(result, 32'h0, "result held in reset");
        check_value(zero, 32'h0, "zero flag held in reset");
        reset = 1'b0;
        check_value(result, 32'h0, "result after reset release");
        check_value(zero, 32'h0, "zero flag after reset release");
        // First edge after release samples the add still on the inputs
        @(posedge clk);
        #1;
        check_value(result, 32'h0, "first sum after reset release");
        check_value(zero, 32'h1, "zero flag on first sum after reset release");
        report_test("reset", fails_before);
    endtask

    task automatic test_basic();
        alu_op_t basic_ops [4];
        data_t   x;
        data_t   y;
        int      round;
        int      k;
        int      fails_before;
        fails_before = fail_count;
        basic_ops = '{op_mov, op_add, op_and, op_or};
        for (round = 0; round < 10; round++) begin
            for (k = 0; k < 4; k++) begin
                random_byte(x);
                random_byte(y);
                apply(basic_ops[k], x, y);
            end
        end
        // Sums that wrap to zero
        apply(op_add, 8'h05, 8'hfb);
        apply(op_and, 8'hfb, 8'h05);
        apply(op_or, 8'h80, 8'h80);
        drain();
        report_test("move/add/and/or", fails_before);
    endtask

    task automatic test_multiply();
        data_t corners [3];
        data_t x;
        data_t y;
        int    i;
        int    j;
        int    fails_before;
        fails_before = fail_count;
        corners = '{8'h00, 8'h01, 8'hff};
        for (i = 0; i < 20; i++) begin
            random_byte(x);
            random_byte(y);
            apply(op_mul, x, y);
        end
        for (i = 0; i < 3; i++) begin
            for (j = 0; j < 3; j++) begin
                apply(op_mul, corners[i], corners[j]);
            end
        end
        drain();
        report_test("multiply", fails_before);
    endtask

    // Amounts -9 to 9, then -128, each on a word with top bit set and clear
    task automatic run_shift_sweep(input alu_op_t op_v, input string name);
        data_t x;
        int    idx;
        int    amt;
        int    fails_before;
        fails_before = fail_count;
        for (idx = 0; idx < 20; idx++) begin
            amt = (idx < 19) ? idx - 9 : -128;
            random_byte(x);
            apply(op_v, x | 8'h80, data_t'(amt));
            apply(op_v, x & 8'h7f, data_t'(amt));
        end
        drain();
        report_test(name, fails_before);
    endtask

    task automatic test_logical_shift();
        run_shift_sweep(op_shl, "logical shift");
    endtask

    task automatic test_arith_shift();
        run_shift_sweep(op_sha, "arithmetic shift");
    endtask

    task automatic test_rotate();
        run_shift_sweep(op_rot, "rotate");
    endtask

    initial begin
        reset = 1'b1;
        op_in = op_mov;
        a_in = '0;
        b_in = '0;
        pend_valid = 1'b0;
        pend_op = op_mov;
        pend_a = '0;
        pend_b = '0;
        pend_result = '0;
        pend_zero = 1'b0;
        lfsr_state = 16'd12;
        pass_count = 0;
        fail_count = 0;
        cycle_count = 0;

        test_reset();
        test_basic();
        test_multiply();
        test_logical_shift();
        test_arith_shift();
        test_rotate();

        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/alu_pkg.sv
hdl/alu_multiplier.sv
hdl/alu_shifter.sv
hdl/alu.sv
verif/alu_tb.sv

// File: Makefile
# Verilator build and run for the ALU testbench

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TOP        ?= alu_tb
RTL_TOP    ?= alu
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing -Wno-fatal
PASS_MSG   ?= *** TEST PASSED ***

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# Lint the design on its own, then with the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) --timing -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Output goes to the terminal, the exit status comes from the search
sim: $(SIM_BIN)
	$(SIM_BIN) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
